// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_top
BUILD_DIR ?= obj_dir
FLIST ?= flist.f
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# The simulator exits non-zero on $fatal or a failed assertion.
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: flist.f
qspi_pkg.sv
qspi_master.sv
scratch_ram.sv
mem_decoder.sv
qspi_soc_top.sv
tb_qspi_device.sv
tb_qspi_assert.sv
tb_top.sv

// File: mem_decoder.sv
module mem_decoder #(
  parameter int ram_words = 16
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         mem_valid,
  input  qspi_pkg::addr_t              mem_addr,
  output qspi_pkg::data_t              mem_rdata,
  output logic                         mem_ready,
  output logic                         ram_valid,
  output logic [$clog2(ram_words)-1:0] ram_index,
  input  qspi_pkg::data_t              ram_rdata,
  input  logic                         ram_ready,
  output logic                         qspi_valid,
  input  qspi_pkg::data_t              qspi_rdata,
  input  logic                         qspi_ready
);

  import qspi_pkg::*;

  localparam int index_width = $clog2(ram_words);

  logic sel_qspi;
  logic route_qspi;
  logic busy_q;
  logic busy_qspi_q;

  assign sel_qspi = mem_addr[region_bit];

  // Once a transfer is under way the captured target steers the mux.
  assign route_qspi = busy_q ? busy_qspi_q : sel_qspi;

  assign ram_valid = mem_valid && !route_qspi;
  assign qspi_valid = mem_valid && route_qspi;

  // Word index without the byte offset bits.
  assign ram_index = mem_addr[3 +: index_width];

  always_ff @(posedge clock) begin
    if (!reset) begin
      busy_q <= 1'b0;
      busy_qspi_q <= 1'b0;
    end else if (mem_ready) begin
      busy_q <= 1'b0;
    end else if (mem_valid && !busy_q) begin
      busy_q <= 1'b1;
      busy_qspi_q <= sel_qspi;
    end
  end

  always_comb begin
    mem_ready = 1'b0;
    mem_rdata = '0;
    if (busy_q || mem_valid) begin
      if (route_qspi) begin
        mem_ready = qspi_ready;
        mem_rdata = qspi_rdata;
      end else begin
        mem_ready = ram_ready;
        mem_rdata = ram_rdata;
      end
    end
  end

endmodule

// File: qspi_master.sv
module qspi_master #(
  parameter int clock_rate = 8
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            mem_valid,
  input  qspi_pkg::strb_t mem_wstrb,
  input  qspi_pkg::data_t mem_wdata,
  output qspi_pkg::data_t mem_rdata,
  output logic            mem_ready,
  output logic            sclk,
  output logic            cs,
  inout  logic            d0,
  inout  logic            d1,
  inout  logic            d2,
  inout  logic            d3
);

  import qspi_pkg::*;

  // System clocks per half period of the serial clock.
  localparam int half = clock_rate / 2;
  localparam int count_width = $clog2(half);
  localparam int nibble_width = $clog2(nibbles_per_byte);

  typedef struct packed {
    logic [count_width-1:0]  counter;
    logic [7:0]              data;
    logic [nibble_width-1:0] nibble;
    logic                    write;
    logic                    read;
    logic                    sclk;
    logic                    ready;
  } register_type;

  register_type r;
  register_type v;

  logic       busy;
  logic       edge_due;
  logic       last_nibble;
  logic       drive_en;
  logic [3:0] lines_in;

  assign busy = r.write | r.read;
  assign edge_due = busy && (r.counter == count_width'(half - 1));
  assign last_nibble = (r.nibble == nibble_width'(nibbles_per_byte - 1));
  assign lines_in = {d3, d2, d1, d0};

  // Lines are only driven while a write is in flight.
  assign drive_en = r.write;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next state.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    v = r;
    v.ready = 1'b0;

    if (busy) begin
      v.counter = r.counter + 1'b1;
    end

    if (edge_due) begin
      v.counter = '0;
      if (!r.sclk) begin
        // Rising edge takes the read nibble.
        v.sclk = 1'b1;
        if (r.read) begin
          v.data = {r.data[3:0], lines_in};
        end
      end else if (last_nibble) begin
        // Final falling edge ends the transfer.
        v.sclk = 1'b0;
        v.write = 1'b0;
        v.read = 1'b0;
        v.ready = 1'b1;
      end else begin
        v.sclk = 1'b0;
        v.nibble = r.nibble + 1'b1;
        if (r.write) begin
          v.data = {r.data[3:0], 4'h0};
        end
      end
    end

    // Valid in the cycle after our own ready belongs to the old request.
    if (mem_valid && !busy && !r.ready) begin
      v.counter = '0;
      v.nibble = '0;
      v.sclk = 1'b0;
      if (|mem_wstrb) begin
        v.write = 1'b1;
        v.data = mem_wdata[7:0];
      end else begin
        v.read = 1'b1;
        v.data = '0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      r <= '0;
    end else begin
      r <= v;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pins and bus response.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign sclk = r.sclk;
  assign cs = ~busy;

  // Upper nibble of the shifter sits on the lines.
  assign d0 = drive_en ? r.data[4] : 1'bz;
  assign d1 = drive_en ? r.data[5] : 1'bz;
  assign d2 = drive_en ? r.data[6] : 1'bz;
  assign d3 = drive_en ? r.data[7] : 1'bz;

  assign mem_ready = r.ready;
  assign mem_rdata = {{(data_width - 8){1'b0}}, r.data};

endmodule

// File: qspi_pkg.sv
package qspi_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Memory bus geometry.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int addr_width = 32;
  localparam int data_width = 64;

  // One strobe per data byte.
  localparam int strb_width = data_width / 8;

  // Address bit 31 set selects the QSPI controller.
  localparam int region_bit = 31;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Quad-SPI framing.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // A byte moves as two nibbles, high nibble first.
  localparam int nibbles_per_byte = 2;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [strb_width-1:0] strb_t;

endpackage

// File: qspi_soc_top.sv
module qspi_soc_top #(
  parameter int clock_rate = 8,
  parameter int ram_words = 16
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            mem_valid,
  input  qspi_pkg::addr_t mem_addr,
  input  qspi_pkg::strb_t mem_wstrb,
  input  qspi_pkg::data_t mem_wdata,
  output qspi_pkg::data_t mem_rdata,
  output logic            mem_ready,
  output logic            sclk,
  output logic            cs,
  inout  logic            d0,
  inout  logic            d1,
  inout  logic            d2,
  inout  logic            d3
);

  import qspi_pkg::*;

  logic                         ram_valid;
  logic [$clog2(ram_words)-1:0] ram_index;
  data_t                        ram_rdata;
  logic                         ram_ready;
  logic                         qspi_valid;
  data_t                        qspi_rdata;
  logic                         qspi_ready;

  mem_decoder #(
    .ram_words(ram_words)
  ) decoder0 (
    .clock(clock),
    .reset(reset),
    .mem_valid(mem_valid),
    .mem_addr(mem_addr),
    .mem_rdata(mem_rdata),
    .mem_ready(mem_ready),
    .ram_valid(ram_valid),
    .ram_index(ram_index),
    .ram_rdata(ram_rdata),
    .ram_ready(ram_ready),
    .qspi_valid(qspi_valid),
    .qspi_rdata(qspi_rdata),
    .qspi_ready(qspi_ready)
  );

  // Strobes and write data go to both slaves unchanged.
  qspi_master #(
    .clock_rate(clock_rate)
  ) qspi0 (
    .clock(clock),
    .reset(reset),
    .mem_valid(qspi_valid),
    .mem_wstrb(mem_wstrb),
    .mem_wdata(mem_wdata),
    .mem_rdata(qspi_rdata),
    .mem_ready(qspi_ready),
    .sclk(sclk),
    .cs(cs),
    .d0(d0),
    .d1(d1),
    .d2(d2),
    .d3(d3)
  );

  scratch_ram #(
    .ram_words(ram_words)
  ) ram0 (
    .clock(clock),
    .reset(reset),
    .mem_valid(ram_valid),
    .mem_index(ram_index),
    .mem_wstrb(mem_wstrb),
    .mem_wdata(mem_wdata),
    .mem_rdata(ram_rdata),
    .mem_ready(ram_ready)
  );

endmodule

// File: scratch_ram.sv
module scratch_ram #(
  parameter int ram_words = 16
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         mem_valid,
  input  logic [$clog2(ram_words)-1:0] mem_index,
  input  qspi_pkg::strb_t              mem_wstrb,
  input  qspi_pkg::data_t              mem_wdata,
  output qspi_pkg::data_t              mem_rdata,
  output logic                         mem_ready
);

  import qspi_pkg::*;

  data_t mem [ram_words];
  data_t rdata_q;
  logic  ready_q;
  logic  accept;

  // The cycle after ready is ignored so a request is taken once.
  assign accept = mem_valid && !ready_q;

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < strb_width; i++) begin
      if (accept && mem_wstrb[i]) begin
        mem[mem_index][8*i +: 8] <= mem_wdata[8*i +: 8];
      end
    end
    if (accept) begin
      rdata_q <= mem[mem_index];
    end
  end

  assign mem_ready = ready_q;
  assign mem_rdata = rdata_q;

endmodule

// File: tb_qspi_assert.sv
module tb_qspi_assert (
  input logic clock,
  input logic reset,
  input logic mem_ready,
  input logic sclk,
  input logic cs,
  input logic read_flag,
  input logic drive_en
);

  timeunit 1ns;
  timeprecision 1ps;

  single_ready: assert property (@(posedge clock) disable iff (!reset) mem_ready |=> !mem_ready)
    else $error("mem_ready high for two cycles in a row");

  reset_pins: assert property (@(posedge clock) !reset |=> (cs && !sclk))
    else $error("cs or sclk not idle after reset");

  // Serial clock stays parked low between transfers.
  idle_sclk: assert property (@(posedge clock) disable iff (!reset) cs |-> !sclk)
    else $error("sclk high while cs is high");

  read_release: assert property (@(posedge clock) disable iff (!reset) read_flag |-> !drive_en)
    else $error("data lines driven by the controller during a read");

endmodule

bind qspi_master tb_qspi_assert assert0 (
  .clock(clock),
  .reset(reset),
  .mem_ready(mem_ready),
  .sclk(sclk),
  .cs(cs),
  .read_flag(r.read),
  .drive_en(drive_en)
);

// File: tb_qspi_device.sv
module tb_qspi_device (
  input logic sclk,
  input logic cs,
  input logic read_mode,
  inout wire  d0,
  inout wire  d1,
  inout wire  d2,
  inout wire  d3
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0] last_byte = 8'h00;
  logic [7:0] shift = 8'h00;
  logic       second = 1'b0;
  logic       drive;
  logic [3:0] nibble;

  assign drive = !cs && read_mode;
  assign nibble = second ? last_byte[3:0] : last_byte[7:4];

  assign d0 = drive ? nibble[0] : 1'bz;
  assign d1 = drive ? nibble[1] : 1'bz;
  assign d2 = drive ? nibble[2] : 1'bz;
  assign d3 = drive ? nibble[3] : 1'bz;

  // Write nibbles are taken on the rising serial clock.
  always @(posedge sclk) begin
    if (!cs && !read_mode) begin
      shift <= {shift[3:0], d3, d2, d1, d0};
    end
  end

  // Chip select rising closes a transfer.
  always @(negedge sclk or posedge cs) begin
    if (cs) begin
      second <= 1'b0;
      if (!read_mode) begin
        last_byte <= shift;
      end
    end else begin
      second <= 1'b1;
    end
  end

endmodule

// File: tb_top.sv
module tb_top;

  timeunit 1ns;
  timeprecision 1ps;

  import qspi_pkg::*;

  logic        clock;
  logic        reset;
  logic        mem_valid;
  addr_t       mem_addr;
  strb_t       mem_wstrb;
  data_t       mem_wdata;
  data_t       mem_rdata;
  logic        mem_ready;
  logic        sclk;
  logic        cs;
  wire         d0;
  wire         d1;
  wire         d2;
  wire         d3;
  logic        device_read;
  logic [31:0] seed;
  data_t       ram_model [16];
  int          cs_rises;

  qspi_soc_top #(
    .clock_rate(8),
    .ram_words(16)
  ) dut0 (
    .clock(clock),
    .reset(reset),
    .mem_valid(mem_valid),
    .mem_addr(mem_addr),
    .mem_wstrb(mem_wstrb),
    .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata),
    .mem_ready(mem_ready),
    .sclk(sclk),
    .cs(cs),
    .d0(d0),
    .d1(d1),
    .d2(d2),
    .d3(d3)
  );

  tb_qspi_device dev0 (
    .sclk(sclk),
    .cs(cs),
    .read_mode(device_read),
    .d0(d0),
    .d1(d1),
    .d2(d2),
    .d3(d3)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge cs) cs_rises++;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic logic [7:0] next_byte();
    logic [31:0] value;
    value = next_random();
    return value[23:16];
  endfunction

  // Expected word after a strobed write.
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
    data_t result;
    result = old_word;
    for (int i = 0; i < strb_width; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "testbench stopped");
  endtask

  task automatic check_data(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
      abort_run("Data value mismatch.");
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAIL %0t %s expected %b actual %b", $time, name, expected, actual);
      abort_run("Signal level mismatch.");
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("FAIL %0t %s expected %0d actual %0d", $time, name, expected, actual);
      abort_run("Count mismatch.");
    end
  endtask

  // One bus request; latency counts rising edges from valid to ready.
  task automatic transfer(input addr_t addr, input strb_t strb, input data_t wdata,
                          output data_t rdata, output int latency);
    @(posedge clock);
    device_read <= addr[region_bit] && (strb == '0);
    mem_addr <= addr;
    mem_wstrb <= strb;
    mem_wdata <= wdata;
    mem_valid <= 1'b1;
    latency = 0;
    @(negedge clock);
    while (!mem_ready) begin
      if (latency == 200) begin
        abort_run("Timeout waiting for mem_ready after mem_valid.");
      end
      @(negedge clock);
      latency++;
    end
    rdata = mem_rdata;
    @(posedge clock);
    mem_valid <= 1'b0;
  endtask

  task automatic bus_write(input addr_t addr, input strb_t strb, input data_t wdata,
                           output int latency);
    data_t ignored;
    transfer(addr, strb, wdata, ignored, latency);
  endtask

  task automatic bus_read(input addr_t addr, output data_t rdata, output int latency);
    transfer(addr, '0, '0, rdata, latency);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_reset_state();
    @(negedge clock);
    check_bit("cs", 1'b1, cs);
    check_bit("sclk", 1'b0, sclk);
    repeat (20) begin
      check_bit("mem_ready", 1'b0, mem_ready);
      @(negedge clock);
    end
  endtask

  task automatic test_ram_round_trip();
    int    latency;
    data_t rdata;
    for (int i = 0; i < 6; i++) begin
      ram_model[i] = {next_random(), next_random()};
      bus_write(addr_t'(i * 8), 8'hff, ram_model[i], latency);
      check_count("ram write latency", 1, latency);
    end
    for (int i = 0; i < 6; i++) begin
      bus_read(addr_t'(i * 8), rdata, latency);
      check_data("mem_rdata", ram_model[i], rdata);
      check_count("ram read latency", 1, latency);
    end
  endtask

  task automatic test_ram_strobes();
    int    latency;
    data_t rdata;
    data_t new_word;
    new_word = {next_random(), next_random()};
    bus_write(addr_t'(16), 8'b1010_0110, new_word, latency);
    ram_model[2] = merge_bytes(ram_model[2], new_word, 8'b1010_0110);
    bus_read(addr_t'(16), rdata, latency);
    check_data("mem_rdata", ram_model[2], rdata);
  endtask

  // Upper 56 bits are random and must not reach the device.
  task automatic test_qspi_write(input logic [7:0] value);
    int    latency;
    int    rises;
    data_t word;
    word = {next_random(), next_random()};
    word[7:0] = value;
    rises = cs_rises;
    bus_write(32'h8000_0000, 8'hff, word, latency);
    check_bit("cs", 1'b1, cs);
    check_count("cs rising edges", rises + 1, cs_rises);
    check_data("device last_byte", data_t'(value), data_t'(dev0.last_byte));
  endtask

  task automatic test_qspi_read(input logic [7:0] value);
    int    latency;
    data_t rdata;
    bus_read(32'h8000_0000, rdata, latency);
    check_data("mem_rdata", data_t'(value), rdata);
  endtask

  task automatic test_alternating();
    int         latency;
    data_t      rdata;
    logic [7:0] value;
    value = next_byte();
    ram_model[7] = {next_random(), next_random()};
    bus_write(addr_t'(56), 8'hff, ram_model[7], latency);
    test_qspi_write(value);
    bus_read(addr_t'(56), rdata, latency);
    check_data("mem_rdata", ram_model[7], rdata);
    test_qspi_read(value);
    bus_read(addr_t'(0), rdata, latency);
    check_data("mem_rdata", ram_model[0], rdata);
    test_qspi_write(~value);
    bus_read(addr_t'(56), rdata, latency);
    check_data("mem_rdata", ram_model[7], rdata);
    test_qspi_read(~value);
  endtask

  initial begin
    logic [7:0] value;
    seed = 32'd91;
    reset = 1'b0;
    mem_valid = 1'b0;
    mem_addr = '0;
    mem_wstrb = '0;
    mem_wdata = '0;
    device_read = 1'b0;
    repeat (8) @(posedge clock);
    reset <= 1'b1;
    test_reset_state();
    test_ram_round_trip();
    test_ram_strobes();
    // Second read shows that a read leaves the device byte alone.
    for (int i = 0; i < 4; i++) begin
      value = next_byte();
      test_qspi_write(value);
      test_qspi_read(value);
      test_qspi_read(value);
    end
    test_alternating();
    $display("Simulation PASSED");
    $finish;
  end

endmodule
